//--- verilog/ranging_pkg.sv
package ranging_pkg;

	//////////////////////////////////////////////////////////////////////
	// sensor array sizing
	//////////////////////////////////////////////////////////////////////

	// trigger, power and echo buses always carry the full array
	// unused bits just idle
	localparam int MAX_SENSORS = 10;
	localparam int SENSOR_IDX_W = 4;

	//////////////////////////////////////////////////////////////////////
	// distance path
	//////////////////////////////////////////////////////////////////////

	// echo count width, wide enough for roughly 38 ms at 27 MHz
	localparam int DIST_W = 20;

	// written when an echo never ends, 19 ones
	localparam logic [DIST_W-1:0] NOTHING_FOUND = DIST_W'(19'h7_ffff);

	// passes per sensor, the median logic assumes three
	localparam int PASSES = 3;

	// location word is {angle code, distance low byte}
	localparam int LOCATION_W = 12;

	// origin code, the angle is meaningless at the origin
	localparam logic [LOCATION_W-1:0] ORIGIN_LOCATION = 12'h100;

endpackage

//--- verilog/sensor_sequencer.sv
module sensor_sequencer import ranging_pkg::*; #(
	parameter int NUM_SENSORS = 6
) (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    calculate,
	input  logic                    pass_valid,
	input  logic                    median_valid,
	input  logic                    median_retry,
	input  logic                    report,
	output logic                    fire,
	output logic [SENSOR_IDX_W-1:0] sensor_index,
	output logic                    scan_start,
	output logic                    scan_end,
	output logic                    done
);

	localparam int PASS_W = $clog2(PASSES + 1);
	localparam logic [SENSOR_IDX_W-1:0] LAST_SENSOR = SENSOR_IDX_W'(NUM_SENSORS - 1);

	// scan states
	localparam logic [1:0] IDLE = 2'd0;
	localparam logic [1:0] MEASURE = 2'd1;
	localparam logic [1:0] REPORT_WAIT = 2'd2;

	logic [1:0] state;
	// passes fired so far for the current sensor
	logic [PASS_W-1:0] pass_count;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			pass_count <= '0;
			sensor_index <= '0;
			fire <= 1'b0;
			scan_start <= 1'b0;
			scan_end <= 1'b0;
			done <= 1'b0;
		end else begin
			// strobes default low
			fire <= 1'b0;
			scan_start <= 1'b0;
			scan_end <= 1'b0;
			case (state)
				IDLE: begin
					// accept a new scan, start at sensor 0 pass one
					if (calculate) begin
						state <= MEASURE;
						scan_start <= 1'b1;
						done <= 1'b0;
						sensor_index <= '0;
						pass_count <= PASS_W'(1);
						fire <= 1'b1;
					end
				end
				MEASURE: begin
					if (pass_valid && (pass_count < PASS_W'(PASSES))) begin
						// more passes needed on this sensor
						fire <= 1'b1;
						pass_count <= pass_count + 1'b1;
					end else if (median_retry) begin
						// zero median, run the whole set again
						fire <= 1'b1;
						pass_count <= PASS_W'(1);
					end else if (median_valid) begin
						if (sensor_index == LAST_SENSOR) begin
							scan_end <= 1'b1;
							state <= REPORT_WAIT;
						end else begin
							// selector samples the old index on this edge
							sensor_index <= sensor_index + 1'b1;
							pass_count <= PASS_W'(1);
							fire <= 1'b1;
						end
					end
				end
				REPORT_WAIT: begin
					// done stays high until the next accepted calculate
					if (report) begin
						done <= 1'b1;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

//--- verilog/echo_timer.sv
module echo_timer import ranging_pkg::*; #(
	parameter int TRIGGER_CYCLES = 275,
	parameter int ECHO_LIMIT = 1048576,
	parameter int ECHO_SHIFT = 12,
	parameter int POWER_OFF_CYCLES = 27000000
) (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    fire,
	input  logic [SENSOR_IDX_W-1:0] sensor_index,
	input  logic [MAX_SENSORS-1:0]  ultrasound_signals,
	output logic [MAX_SENSORS-1:0]  ultrasound_commands,
	output logic [MAX_SENSORS-1:0]  ultrasound_power,
	output logic                    pass_valid,
	output logic [DIST_W-1:0]       pass_distance
);

	localparam int TRIG_W = $clog2(TRIGGER_CYCLES + 1);
	localparam int OFF_W = $clog2(POWER_OFF_CYCLES + 1);
	// count value at which a stuck echo is given up
	localparam logic [DIST_W-1:0] ECHO_END = DIST_W'(ECHO_LIMIT - 1);

	//////////////////////////////////////////////////////////////////////
	// measurement states
	//////////////////////////////////////////////////////////////////////

	localparam logic [2:0] IDLE = 3'd0;
	localparam logic [2:0] TRIGGER = 3'd1;
	localparam logic [2:0] WAIT_RISE = 3'd2;
	localparam logic [2:0] COUNT = 3'd3;
	localparam logic [2:0] POWER_OFF = 3'd4;

	logic [2:0] state;
	logic [TRIG_W-1:0] trig_count;
	logic [OFF_W-1:0] off_count;
	logic [DIST_W-1:0] echo_count;
	logic echo;

	// echo line of the sensor being measured
	assign echo = ultrasound_signals[sensor_index];

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			trig_count <= '0;
			off_count <= '0;
			echo_count <= '0;
			ultrasound_commands <= '0;
			// every sensor powered out of reset
			ultrasound_power <= '1;
			pass_valid <= 1'b0;
		end else begin
			pass_valid <= 1'b0;
			case (state)
				IDLE: begin
					if (fire) begin
						ultrasound_commands[sensor_index] <= 1'b1;
						trig_count <= TRIG_W'(1);
						state <= TRIGGER;
					end
				end
				TRIGGER: begin
					// trigger held for exactly TRIGGER_CYCLES
					if (trig_count == TRIG_W'(TRIGGER_CYCLES)) begin
						ultrasound_commands[sensor_index] <= 1'b0;
						state <= WAIT_RISE;
					end else begin
						trig_count <= trig_count + 1'b1;
					end
				end
				WAIT_RISE: begin
					// first high sample counts as one
					if (echo) begin
						echo_count <= DIST_W'(1);
						state <= COUNT;
					end
				end
				COUNT: begin
					if (!echo) begin
						// count now equals the high width
						pass_valid <= 1'b1;
						state <= IDLE;
					end else if (echo_count == ECHO_END) begin
						// stuck sensor, cut its power for a while
						ultrasound_power[sensor_index] <= 1'b0;
						off_count <= OFF_W'(1);
						state <= POWER_OFF;
					end else begin
						echo_count <= echo_count + 1'b1;
					end
				end
				POWER_OFF: begin
					// power low for exactly POWER_OFF_CYCLES
					if (off_count == OFF_W'(POWER_OFF_CYCLES)) begin
						ultrasound_power[sensor_index] <= 1'b1;
						pass_valid <= 1'b1;
						state <= IDLE;
					end else begin
						off_count <= off_count + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// scaled distance, or the sentinel on timeout
	always_ff @(posedge clock) begin
		if (state == COUNT) begin
			if (!echo) begin
				pass_distance <= echo_count >> ECHO_SHIFT;
			end else if (echo_count == ECHO_END) begin
				pass_distance <= NOTHING_FOUND;
			end
		end
	end

endmodule

//--- verilog/median_filter.sv
module median_filter import ranging_pkg::*; (
	input  logic              clock,
	input  logic              reset,
	input  logic              pass_valid,
	input  logic [DIST_W-1:0] pass_distance,
	output logic              median_valid,
	output logic              median_retry,
	output logic [DIST_W-1:0] median_distance
);

	localparam int CNT_W = $clog2(PASSES);

	// one slot per pass
	logic [DIST_W-1:0] pass_regs [PASSES];
	logic [CNT_W-1:0] pass_count;
	// high the cycle after the last pass lands
	logic median_ready;

	// middle of three by min/max
	function automatic logic [DIST_W-1:0] median3(
		input logic [DIST_W-1:0] a,
		input logic [DIST_W-1:0] b,
		input logic [DIST_W-1:0] c
	);
		logic [DIST_W-1:0] lo;
		logic [DIST_W-1:0] hi;
		logic [DIST_W-1:0] mid;
		lo = (a < b) ? a : b;
		hi = (a < b) ? b : a;
		mid = (hi < c) ? hi : c;
		return (lo > mid) ? lo : mid;
	endfunction

	always_ff @(posedge clock) begin
		if (reset) begin
			pass_count <= '0;
			median_ready <= 1'b0;
		end else begin
			median_ready <= 1'b0;
			if (pass_valid) begin
				// wrap after the last pass, a retry starts fresh
				if (pass_count == CNT_W'(PASSES - 1)) begin
					pass_count <= '0;
					median_ready <= 1'b1;
				end else begin
					pass_count <= pass_count + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (pass_valid) begin
			pass_regs[pass_count] <= pass_distance;
		end
	end

	assign median_distance = median3(pass_regs[0], pass_regs[1], pass_regs[2]);

	// zero median means a bad reading, ask for another set
	assign median_valid = median_ready && (median_distance != '0);
	assign median_retry = median_ready && (median_distance == '0);

endmodule

//--- verilog/nearest_selector.sv
module nearest_selector import ranging_pkg::*; #(
	parameter int DISTANCE_OFFSET = 5
) (
	input  logic                    clock,
	input  logic                    reset,
	input  logic                    scan_start,
	input  logic                    median_valid,
	input  logic [DIST_W-1:0]       median_distance,
	input  logic [SENSOR_IDX_W-1:0] sensor_index,
	input  logic                    scan_end,
	output logic [LOCATION_W-1:0]   rover_location,
	output logic                    report
);

	localparam int ANGLE_W = 4;
	localparam int LOC_DIST_W = LOCATION_W - ANGLE_W;

	logic best_valid;
	logic [DIST_W-1:0] best_distance;
	logic [ANGLE_W-1:0] best_angle;
	logic [DIST_W-1:0] candidate;
	logic [ANGLE_W-1:0] angle;
	logic take;

	// offset corrects for the sensor housing
	assign candidate = median_distance + DIST_W'(DISTANCE_OFFSET);

	// odd codes, sensors sit between the 15 degree marks
	assign angle = ANGLE_W'(2 * sensor_index + 1);

	// sentinel never wins; equal distance keeps the lower index
	assign take = median_valid && (median_distance != NOTHING_FOUND) &&
		(!best_valid || (candidate < best_distance));

	always_ff @(posedge clock) begin
		if (reset) begin
			best_valid <= 1'b0;
			rover_location <= '0;
			report <= 1'b0;
		end else begin
			report <= 1'b0;
			if (scan_start) begin
				best_valid <= 1'b0;
			end else if (take) begin
				best_valid <= 1'b1;
			end
			if (scan_end) begin
				rover_location <= best_valid ?
					{best_angle, best_distance[LOC_DIST_W-1:0]} : ORIGIN_LOCATION;
				report <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (take) begin
			best_distance <= candidate;
			best_angle <= angle;
		end
	end

endmodule

//--- verilog/rover_locator_top.sv
module rover_locator_top import ranging_pkg::*; #(
	parameter int NUM_SENSORS = 6,
	parameter int TRIGGER_CYCLES = 275,
	parameter int ECHO_LIMIT = 1048576,
	parameter int ECHO_SHIFT = 12,
	parameter int POWER_OFF_CYCLES = 27000000,
	parameter int DISTANCE_OFFSET = 5
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  calculate,
	input  logic [MAX_SENSORS-1:0] ultrasound_signals,
	output logic [MAX_SENSORS-1:0] ultrasound_commands,
	output logic [MAX_SENSORS-1:0] ultrasound_power,
	output logic                  done,
	output logic [LOCATION_W-1:0] rover_location
);

	//////////////////////////////////////////////////////////////////////
	// stage to stage strobes and data
	//////////////////////////////////////////////////////////////////////

	logic fire;
	logic [SENSOR_IDX_W-1:0] sensor_index;
	logic pass_valid;
	logic [DIST_W-1:0] pass_distance;
	logic median_valid;
	logic median_retry;
	logic [DIST_W-1:0] median_distance;
	logic scan_start;
	logic scan_end;
	logic report;

	// stage 1, picks sensor and pass
	sensor_sequencer #(
		.NUM_SENSORS(NUM_SENSORS)
	) u_sequencer (
		.clock(clock),
		.reset(reset),
		.calculate(calculate),
		.pass_valid(pass_valid),
		.median_valid(median_valid),
		.median_retry(median_retry),
		.report(report),
		.fire(fire),
		.sensor_index(sensor_index),
		.scan_start(scan_start),
		.scan_end(scan_end),
		.done(done)
	);

	// stage 2, drives the sensor buses
	echo_timer #(
		.TRIGGER_CYCLES(TRIGGER_CYCLES),
		.ECHO_LIMIT(ECHO_LIMIT),
		.ECHO_SHIFT(ECHO_SHIFT),
		.POWER_OFF_CYCLES(POWER_OFF_CYCLES)
	) u_echo_timer (
		.clock(clock),
		.reset(reset),
		.fire(fire),
		.sensor_index(sensor_index),
		.ultrasound_signals(ultrasound_signals),
		.ultrasound_commands(ultrasound_commands),
		.ultrasound_power(ultrasound_power),
		.pass_valid(pass_valid),
		.pass_distance(pass_distance)
	);

	// stage 3
	median_filter u_median (
		.clock(clock),
		.reset(reset),
		.pass_valid(pass_valid),
		.pass_distance(pass_distance),
		.median_valid(median_valid),
		.median_retry(median_retry),
		.median_distance(median_distance)
	);

	// stage 4, keeps the nearest target
	nearest_selector #(
		.DISTANCE_OFFSET(DISTANCE_OFFSET)
	) u_selector (
		.clock(clock),
		.reset(reset),
		.scan_start(scan_start),
		.median_valid(median_valid),
		.median_distance(median_distance),
		.sensor_index(sensor_index),
		.scan_end(scan_end),
		.rover_location(rover_location),
		.report(report)
	);

endmodule

//--- testbench/rover_locator_chk.sv
module rover_locator_chk import ranging_pkg::*; (
	input logic                   clock,
	input logic                   reset,
	input logic                   report,
	input logic                   done,
	input logic [MAX_SENSORS-1:0] ultrasound_commands,
	input logic [MAX_SENSORS-1:0] ultrasound_power
);
	timeunit 1ns;
	timeprecision 100ps;

	// done only rises on the edge that sees the selector report
	done_needs_report: assert property (@(posedge clock) disable iff (reset)
		$rose(done) |-> $past(report))
		else $error("done rose with no report on the cycle before");

	// sensors fire one at a time
	one_trigger: assert property (@(posedge clock) disable iff (reset)
		$onehot0(ultrasound_commands))
		else $error("more than one trigger line high");

	// an unpowered sensor is never triggered
	trigger_powered: assert property (@(posedge clock) disable iff (reset)
		(ultrasound_commands & ~ultrasound_power) == '0)
		else $error("trigger high on a sensor with its power off");

endmodule

bind rover_locator_top rover_locator_chk chk (
	.clock(clock),
	.reset(reset),
	.report(report),
	.done(done),
	.ultrasound_commands(ultrasound_commands),
	.ultrasound_power(ultrasound_power)
);

//--- testbench/rover_locator_tb.sv
module rover_locator_tb import ranging_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_SENSORS = 4;
	localparam int DONE_TIMEOUT = 5000;
	localparam string TRACE_FILE = "testbench/rover_locator_trace.txt";

	// echo model phases
	localparam int M_IDLE = 0;
	localparam int M_PICK = 1;
	localparam int M_DELAY = 2;
	localparam int M_HIGH = 3;
	localparam int M_STUCK = 4;

	logic clock;
	logic reset;
	logic calculate;
	logic [MAX_SENSORS-1:0] ultrasound_signals = '0;
	logic [MAX_SENSORS-1:0] ultrasound_commands;
	logic [MAX_SENSORS-1:0] ultrasound_power;
	logic done;
	logic [LOCATION_W-1:0] rover_location;

	// trace contents with the widths of all tests back to back
	string test_names[$];
	int width_counts[$];
	logic [LOCATION_W-1:0] expected_locations[$];
	int all_widths[$];
	int width_limit = 0;

	// echo model state
	int next_width = 0;
	int model_phase = M_IDLE;
	int echo_left = 0;
	int delay_left = 0;
	int power_drops = 0;
	int trace_misses = 0;
	logic [SENSOR_IDX_W-1:0] echo_sensor = '0;
	logic [31:0] rng = 32'h4ff6;
	logic [MAX_SENSORS-1:0] last_commands = '0;
	logic [MAX_SENSORS-1:0] last_power = '1;

	int test_errors = 0;
	int total_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	bit stalled = 1'b0;

	rover_locator_top #(
		.NUM_SENSORS(NUM_SENSORS),
		.TRIGGER_CYCLES(5),
		.ECHO_LIMIT(50),
		.ECHO_SHIFT(1),
		.POWER_OFF_CYCLES(12),
		.DISTANCE_OFFSET(5)
	) uut (
		.clock(clock),
		.reset(reset),
		.calculate(calculate),
		.ultrasound_signals(ultrasound_signals),
		.ultrasound_commands(ultrasound_commands),
		.ultrasound_power(ultrasound_power),
		.done(done),
		.rover_location(rover_location)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// sensor echo model
	//////////////////////////////////////////////////////////////////////

	// a falling trigger starts the next echo from the trace
	always @(negedge clock) begin
		if (!reset) begin
			power_drops += $countones(last_power & ~ultrasound_power);
			if (model_phase == M_IDLE && (last_commands & ~ultrasound_commands) != '0) begin
				// only one trigger can be high so the fallen bit is a power of two
				echo_sensor = SENSOR_IDX_W'($clog2(last_commands & ~ultrasound_commands));
				model_phase = M_PICK;
			end
			case (model_phase)
				M_PICK: begin
					if (next_width >= width_limit) begin
						trace_misses++;
						model_phase = M_IDLE;
					end else begin
						echo_left = all_widths[next_width];
						next_width++;
						rng = xorshift32(rng);
						// rise 1 to 8 cycles after the trigger
						delay_left = int'(rng[2:0]) + 1;
						model_phase = M_DELAY;
					end
				end
				M_DELAY: begin
					delay_left--;
					if (delay_left == 0) begin
						ultrasound_signals[echo_sensor] = 1'b1;
						model_phase = (echo_left == 0) ? M_STUCK : M_HIGH;
					end
				end
				M_HIGH: begin
					// high for exactly echo_left rising edges
					echo_left--;
					if (echo_left == 0) begin
						ultrasound_signals[echo_sensor] = 1'b0;
						model_phase = M_IDLE;
					end
				end
				M_STUCK: begin
					// a stuck echo ends only when its sensor loses power
					if (!ultrasound_power[echo_sensor]) begin
						ultrasound_signals[echo_sensor] = 1'b0;
						model_phase = M_IDLE;
					end
				end
				default: model_phase = M_IDLE;
			endcase
		end
		last_commands = ultrasound_commands;
		last_power = ultrasound_power;
	end

	//////////////////////////////////////////////////////////////////////
	// checks and trace handling
	//////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("FAILED %s %s expected %0h actual %0h", name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic close_test(input string name);
		if (test_errors == 0) begin
			tests_passed++;
			$display("test %s passed", name);
		end else begin
			tests_failed++;
			total_errors += test_errors;
			$display("test %s failed with %0d errors", name, test_errors);
		end
	endtask

	task automatic read_trace();
		int fd;
		int code;
		int count;
		int width;
		string key;
		logic [8*32-1:0] word;
		logic [8*160-1:0] line;
		logic [LOCATION_W-1:0] location;
		fd = $fopen(TRACE_FILE, "r");
		assert (fd != 0) else begin
			$display("cannot open the trace file %s", TRACE_FILE);
			total_errors++;
		end
		// one keyword starts each record
		while (fd != 0 && $fscanf(fd, "%s", word) == 1) begin
			key = string'(word);
			if (key == "#") begin
				code = $fgets(line, fd);
			end else if (key == "test") begin
				code = $fscanf(fd, "%s %d", word, count);
				key = string'(word);
				test_names.push_back(key);
				width_counts.push_back(count);
				for (int i = 0; i < count; i++) begin
					code = $fscanf(fd, "%d", width);
					all_widths.push_back(width);
				end
			end else begin
				assert (key == "expect") else begin
					$display("unknown keyword %s in the trace file", key);
					total_errors++;
				end
				if (key == "expect") begin
					code = $fscanf(fd, "%h", location);
					expected_locations.push_back(location);
				end
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end
	endtask

	task automatic run_test(input string name, input int start, input int count,
		input logic [LOCATION_W-1:0] expected);
		int zeros;
		int drops_before;
		int cycles;
		test_errors = 0;
		zeros = 0;
		// every never-ending echo costs one power cycle
		for (int i = start; i < start + count; i++) begin
			if (all_widths[i] == 0) begin
				zeros++;
			end
		end
		width_limit = start + count;
		drops_before = power_drops;
		calculate = 1'b1;
		@(negedge clock);
		calculate = 1'b0;
		check_value(name, "done after calculate", 32'h0, 32'(done));
		// a calculate while busy has no effect
		// sent once the fifth echo is under way so a restart would show
		cycles = 0;
		while (next_width < start + 5 && cycles < DONE_TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		calculate = 1'b1;
		@(negedge clock);
		calculate = 1'b0;
		cycles = 0;
		while (done !== 1'b1 && cycles < DONE_TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		assert (done === 1'b1) else begin
			$display("test %s: done did not rise within %0d cycles", name, DONE_TIMEOUT);
			test_errors++;
			stalled = 1'b1;
		end
		assert (trace_misses == 0) else begin
			$display("test %s: a sensor fired after its echo widths ran out", name);
			test_errors++;
		end
		check_value(name, "location", 32'(expected), 32'(rover_location));
		check_value(name, "power", 32'h3ff, 32'(ultrasound_power));
		check_value(name, "power drops", 32'(zeros), 32'(power_drops - drops_before));
		check_value(name, "echo widths used", 32'(width_limit), 32'(next_width));
		close_test(name);
	endtask

	initial begin
		int start;
		reset = 1'b1;
		calculate = 1'b0;
		read_trace();
		repeat (16) @(negedge clock);
		reset = 1'b0;
		@(negedge clock);
		// idle outputs straight after reset
		test_errors = 0;
		check_value("reset_outputs", "done", 32'h0, 32'(done));
		check_value("reset_outputs", "location", 32'h0, 32'(rover_location));
		check_value("reset_outputs", "triggers", 32'h0, 32'(ultrasound_commands));
		check_value("reset_outputs", "power", 32'h3ff, 32'(ultrasound_power));
		close_test("reset_outputs");
		assert (test_names.size() > 0 && test_names.size() == expected_locations.size())
		else begin
			$display("the trace file holds no complete test");
			total_errors++;
		end
		// tests run in trace order and share one echo list
		start = 0;
		for (int t = 0; t < expected_locations.size() && !stalled; t++) begin
			run_test(test_names[t], start, width_counts[t], expected_locations[t]);
			start += width_counts[t];
		end
		$display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
			total_errors);
		if (total_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- testbench/rover_locator_trace.txt
# test <name> <width count>, then echo widths in firing order, 0 means the echo never falls
# expect <location in hex> with the angle code in the top nibble and the distance below
test median_nearest 12
30 20 24  10 14 12  40 44 42  12 13 16
expect 30b
test median_outliers 12
20 48 22  30 2 28  3 16 18  14 15 46
expect 70c
test zero_retry 18
1 1 1  20 22 24  26 26 26  1 30 1  8 9 10  36 34 38
expect 509
test timeout_power 12
0 0 0  0 0 0  0 0 0  0 0 0
expect 100
test back_to_back 12
0 40 42  44 46 48  34 0 0  24 26 22
expect 711

//--- flist.f
verilog/ranging_pkg.sv
verilog/sensor_sequencer.sv
verilog/echo_timer.sv
verilog/median_filter.sv
verilog/nearest_selector.sv
verilog/rover_locator_top.sv
testbench/rover_locator_chk.sv
testbench/rover_locator_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the rover locator testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module rover_locator_tb \
	-f flist.f -o rover_locator_sim || { echo "verilator build failed"; exit 1; }
output=$(./obj_dir/rover_locator_sim 2>&1)
echo "$output"
echo "$output" | grep -q "^Finished with no errors$" && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
